// File: all.f
+incdir+verif
verilog/sw_pkg.sv
verilog/sw_cell.sv
verilog/sw_array.sv
verilog/sw_best_select.sv
verilog/sw_ctrl.sv
verilog/sw_core.sv
verif/sw_tb.sv

// File: verif/sw_ref.svh
// expected-result model; include inside a module that imports sw_pkg and defines REF_LEN, READ_LEN
`ifndef SW_REF_SVH
`define SW_REF_SVH

// one job's best cell, row and column both 0-based
typedef struct packed {
    int score;
    int row;
    int col;
} result_t;

function automatic int larger_of3(input int a, input int b, input int c);
    int ab;
    ab = (a > b) ? a : b;
    return (ab > c) ? ab : c;
endfunction

function automatic result_t expected_alignment(
    input logic [2*REF_LEN-1:0]  seq_ref,
    input logic [2*READ_LEN-1:0] seq_read,
    input int                    ref_len,
    input int                    read_len
);
    // index 0 is the zero border outside the matrix
    int         m_mat [0:READ_LEN][0:REF_LEN];
    int         i_mat [0:READ_LEN][0:REF_LEN];
    int         d_mat [0:READ_LEN][0:REF_LEN];
    int         r;
    int         c;
    int         sub;
    int         row_best;
    int         row_col;
    logic [1:0] rb;
    logic [1:0] cb;
    result_t    res;

    for (r = 0; r <= READ_LEN; r++) begin
        for (c = 0; c <= REF_LEN; c++) begin
            m_mat[r][c] = 0;
            i_mat[r][c] = 0;
            d_mat[r][c] = 0;
        end
    end
    res.score = 0;
    res.row   = 0;
    res.col   = 0;
    for (r = 1; r <= read_len; r++) begin
        // first base sits in the top pair
        rb       = seq_read[2*(READ_LEN-r)+1 -: 2];
        row_best = 0;
        row_col  = 0;
        for (c = 1; c <= ref_len; c++) begin
            cb  = seq_ref[2*(REF_LEN-c)+1 -: 2];
            sub = (rb == cb) ? MATCH_SCORE : MISMATCH_SCORE;
            m_mat[r][c] = larger_of3(m_mat[r-1][c-1], i_mat[r-1][c-1], d_mat[r-1][c-1]) + sub;
            if (m_mat[r][c] < 0)
                m_mat[r][c] = 0;
            i_mat[r][c] = larger_of3(m_mat[r-1][c] + GAP_OPEN, i_mat[r-1][c] + GAP_EXTEND, 0);
            d_mat[r][c] = larger_of3(m_mat[r][c-1] + GAP_OPEN, d_mat[r][c-1] + GAP_EXTEND, 0);
            // ties keep the earliest column
            if (m_mat[r][c] > row_best) begin
                row_best = m_mat[r][c];
                row_col  = c - 1;
            end
        end
        // ties keep the lowest row
        if (row_best > res.score) begin
            res.score = row_best;
            res.row   = r - 1;
            res.col   = row_col;
        end
    end
    return res;
endfunction

`endif

// File: verif/sw_tb.sv
// directed and seeded random jobs against the default sizes; results are checked in job order
`timescale 1ns/10ps

module sw_tb import sw_pkg::*; ();

    localparam int REF_LEN         = 16;
    localparam int READ_LEN        = 8;
    localparam int SCORE_W         = 10;
    localparam int COL_W           = $clog2(REF_LEN);
    localparam int ROW_W           = $clog2(READ_LEN);
    localparam int RLEN_W          = $clog2(REF_LEN) + 1;
    localparam int QLEN_W          = $clog2(READ_LEN) + 1;
    localparam int CLK_PERIOD      = 40;
    localparam int DRIVE_DLY       = 2;
    localparam int N_DIRECTED      = 10;
    localparam int N_RANDOM        = 200;
    localparam int N_HANDSHAKE     = 12;
    localparam int JOB_CYCLES      = REF_LEN + 2*READ_LEN + 10;
    localparam int WATCHDOG_CYCLES = (N_DIRECTED + N_RANDOM + N_HANDSHAKE) * JOB_CYCLES + 200;

    `include "sw_ref.svh"

    logic                      clk;
    logic                      rst;
    logic                      i_valid;
    logic [2*REF_LEN-1:0]      i_seq_ref;
    logic [2*READ_LEN-1:0]     i_seq_read;
    logic [RLEN_W-1:0]         i_ref_len;
    logic [QLEN_W-1:0]         i_read_len;
    logic                      o_ready;
    logic                      i_ready;
    logic                      o_valid;
    logic signed [SCORE_W-1:0] o_score;
    logic [ROW_W-1:0]          o_row;
    logic [COL_W-1:0]          o_col;

    integer  seed = 32'hbcd5;
    int      value_errors = 0;
    int      proto_errors = 0;
    int      n_jobs = 0;
    int      n_results = 0;
    result_t exp_q[$];
    result_t front_exp;

    sw_core #(.REF_LEN(REF_LEN), .READ_LEN(READ_LEN), .SCORE_W(SCORE_W)) dut_i (
        .clk(clk), .rst(rst), .i_valid(i_valid), .i_seq_ref(i_seq_ref),
        .i_seq_read(i_seq_read), .i_ref_len(i_ref_len), .i_read_len(i_read_len),
        .o_ready(o_ready), .i_ready(i_ready), .o_valid(o_valid),
        .o_score(o_score), .o_row(o_row), .o_col(o_col)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("ERROR: run timed out after %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    // result is taken at the next rising edge
    always @(negedge clk) begin
        if (!rst && o_valid && i_ready) begin
            n_results++;
            if (exp_q.size() == 0) begin
                $display("ERROR: result returned at %0t ns with no job outstanding", $time);
                proto_errors++;
            end else begin
                front_exp = exp_q.pop_front();
                assert (o_score == front_exp.score) else begin
                    $display("[FAIL] %0t ns: score %0d, expected %0d", $time, o_score,
                             front_exp.score);
                    value_errors++;
                end
                assert (o_row == front_exp.row) else begin
                    $display("[FAIL] %0t ns: row %0d, expected %0d", $time, o_row, front_exp.row);
                    value_errors++;
                end
                assert (o_col == front_exp.col) else begin
                    $display("[FAIL] %0t ns: col %0d, expected %0d", $time, o_col, front_exp.col);
                    value_errors++;
                end
            end
        end
    end

    task automatic step_cycle();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    // string of A/C/G/T into a bus of the given number of base slots
    function automatic logic [2*REF_LEN-1:0] encode_bases(input string s, input int slots);
        logic [2*REF_LEN-1:0] v;
        logic [1:0]           code;
        int                   k;
        v = '0;
        for (k = 0; k < s.len(); k++) begin
            case (s[k])
                "C":     code = BASE_C;
                "G":     code = BASE_G;
                "T":     code = BASE_T;
                default: code = BASE_A;
            endcase
            v[2*(slots-1-k) +: 2] = code;
        end
        return v;
    endfunction

    task automatic send_job(
        input logic [2*REF_LEN-1:0]  seq_ref,
        input logic [2*READ_LEN-1:0] seq_read,
        input int                    ref_len,
        input int                    read_len,
        input int                    hold,
        input bit                    poke_busy
    );
        logic signed [SCORE_W-1:0] held_score;
        logic [ROW_W-1:0]          held_row;
        logic [COL_W-1:0]          held_col;
        int                        k;
        while (!o_ready)
            step_cycle();
        exp_q.push_back(expected_alignment(seq_ref, seq_read, ref_len, read_len));
        n_jobs++;
        i_valid    = 1'b1;
        i_seq_ref  = seq_ref;
        i_seq_read = seq_read;
        i_ref_len  = RLEN_W'(ref_len);
        i_read_len = QLEN_W'(read_len);
        step_cycle();
        i_valid = 1'b0;
        if (poke_busy) begin
            // offer a second job while the first is running
            step_cycle();
            i_valid   = 1'b1;
            i_seq_ref = ~seq_ref;
            assert (!o_ready) else begin
                $display("ERROR: o_ready high at %0t ns while a job is running", $time);
                proto_errors++;
            end
            step_cycle();
            i_valid = 1'b0;
        end
        while (!o_valid)
            step_cycle();
        held_score = o_score;
        held_row   = o_row;
        held_col   = o_col;
        for (k = 0; k < hold; k++) begin
            i_valid = poke_busy;
            step_cycle();
            assert (o_valid && !o_ready) else begin
                $display("ERROR: handshake flags changed at %0t ns while the result was held",
                         $time);
                proto_errors++;
            end
            assert (o_score == held_score && o_row == held_row && o_col == held_col) else begin
                $display("[FAIL] %0t ns: held result moved to score %0d row %0d col %0d",
                         $time, o_score, o_row, o_col);
                value_errors++;
            end
        end
        i_valid = 1'b0;
        i_ready = 1'b1;
        step_cycle();
        i_ready = 1'b0;
    endtask

    task automatic align_strings(input string ref_s, input string read_s, input int known_score);
        logic [2*REF_LEN-1:0] read_full;
        result_t              model;
        read_full = encode_bases(read_s, READ_LEN);
        model     = expected_alignment(encode_bases(ref_s, REF_LEN),
                                       read_full[2*READ_LEN-1:0], ref_s.len(), read_s.len());
        // sanity of the model on cases with an obvious answer
        if (known_score >= 0) begin
            assert (model.score == known_score) else begin
                $display("[FAIL] %0t ns: model score %0d for %s/%s, expected %0d",
                         $time, model.score, ref_s, read_s, known_score);
                value_errors++;
            end
        end
        send_job(encode_bases(ref_s, REF_LEN), read_full[2*READ_LEN-1:0],
                 ref_s.len(), read_s.len(), 0, 1'b0);
    endtask

    task automatic random_job(input int ref_len, input int read_len, input int hold,
                              input bit poke_busy);
        logic [2*REF_LEN-1:0]  rnd_ref;
        logic [2*READ_LEN-1:0] rnd_read;
        int                    b;
        for (b = 0; b < REF_LEN; b++)
            rnd_ref[2*b +: 2] = 2'({$random(seed)});
        for (b = 0; b < READ_LEN; b++)
            rnd_read[2*b +: 2] = 2'({$random(seed)});
        send_job(rnd_ref, rnd_read, ref_len, read_len, hold, poke_busy);
    endtask

    initial begin : main_seq
        int k;
        int rlen;
        int qlen;
        rst        = 1'b1;
        i_valid    = 1'b0;
        i_seq_ref  = '0;
        i_seq_read = '0;
        i_ref_len  = '0;
        i_read_len = '0;
        i_ready    = 1'b0;
        repeat (2) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;
        assert (o_ready && !o_valid) else begin
            $display("ERROR: after reset o_ready is not high or o_valid is not low");
            proto_errors++;
        end

        // exact matches
        align_strings("CCGATTACAGGT", "GATTACA", MATCH_SCORE * 7);
        align_strings("ACGTTGCAACGTTGCA", "TTGCAACG", MATCH_SCORE * 8);
        align_strings("G", "G", MATCH_SCORE);
        // one mismatch, one insertion, one deletion
        align_strings("AACCGGTTAC", "ACCGATTA", -1);
        align_strings("TTACGTACGG", "ACGGTAC", -1);
        align_strings("GGACGTACGTT", "ACGACG", -1);
        // earliest column and lowest row on ties
        align_strings("ACGTACGT", "ACG", MATCH_SCORE * 3);
        align_strings("TAT", "AGA", MATCH_SCORE);
        // no common base at all
        align_strings("ACCAACACCA", "GTTG", 0);
        align_strings("ACCAACACCAACACCA", "GTTGGTGT", 0);

        for (k = 0; k < N_RANDOM; k++) begin
            rlen = 1 + ({$random(seed)} % REF_LEN);
            qlen = 1 + ({$random(seed)} % READ_LEN);
            case (k % 8)
                0: rlen = 1;
                1: rlen = REF_LEN;
                2: qlen = 1;
                3: qlen = READ_LEN;
                4: begin
                    rlen = REF_LEN;
                    qlen = READ_LEN;
                end
                default: ;
            endcase
            random_job(rlen, qlen, {$random(seed)} % 4, 1'b0);
        end

        // long holds with jobs offered while busy
        for (k = 0; k < N_HANDSHAKE; k++) begin
            rlen = 2 + ({$random(seed)} % (REF_LEN - 1));
            qlen = 2 + ({$random(seed)} % (READ_LEN - 1));
            random_job(rlen, qlen, 1 + ({$random(seed)} % 8), 1'b1);
        end

        // nothing may come back once every job is done
        i_ready = 1'b1;
        repeat (JOB_CYCLES)
            step_cycle();
        i_ready = 1'b0;
        assert (exp_q.size() == 0 && n_results == n_jobs) else begin
            $display("ERROR: %0d jobs accepted but %0d results returned", n_jobs, n_results);
            proto_errors++;
        end
        $display("jobs %0d, value errors %0d, protocol errors %0d",
                 n_jobs, value_errors, proto_errors);
        if (value_errors + proto_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: verilog/sw_array.sv
// systolic row of READ_LEN cells; rows at or beyond the read length hold their cleared state
`timescale 1ns/10ps

module sw_array import sw_pkg::*; #(
    parameter  int REF_LEN  = 16,
    parameter  int READ_LEN = 8,
    parameter  int SCORE_W  = 10,
    localparam int COL_W    = (REF_LEN > 1) ? $clog2(REF_LEN) : 1,
    localparam int QLEN_W   = $clog2(READ_LEN) + 1
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         i_clear,
    input  logic                         i_base_valid,
    input  base_t                        i_base,
    input  logic [COL_W-1:0]             i_base_col,
    input  logic [2*READ_LEN-1:0]        i_read_bases,
    input  logic [QLEN_W-1:0]            i_read_len,
    output logic [READ_LEN*SCORE_W-1:0]  o_row_best,
    output logic [READ_LEN*COL_W-1:0]    o_row_best_col
);

    // chain index j feeds cell j, index 0 is the matrix top edge
    logic signed [SCORE_W-1:0] m_chain     [0:READ_LEN];
    logic signed [SCORE_W-1:0] i_chain     [0:READ_LEN];
    logic                      valid_chain [0:READ_LEN];
    base_t                     base_chain  [0:READ_LEN];
    logic [COL_W-1:0]          col_chain   [0:READ_LEN];

    logic [READ_LEN-1:0]       row_en;

    // outside the matrix every score is 0
    assign m_chain[0]     = '0;
    assign i_chain[0]     = '0;

    // reference stream enters at row 0
    assign valid_chain[0] = i_base_valid;
    assign base_chain[0]  = i_base;
    assign col_chain[0]   = i_base_col;

    genvar j;
    generate
        for (j = 0; j < READ_LEN; j++) begin : g_row
            base_t read_base;

            // first base sits in the top pair of the read bus
            assign read_base = base_t'(i_read_bases[2*(READ_LEN-j)-1 -: 2]);
            assign row_en[j] = (QLEN_W'(j) < i_read_len);

            sw_cell #(
                .REF_LEN (REF_LEN),
                .SCORE_W (SCORE_W)
            ) cell_i (
                .clk            (clk),
                .rst            (rst),
                .i_clear        (i_clear),
                .i_row_en       (row_en[j]),
                .i_read_base    (read_base),
                .i_base_valid   (valid_chain[j]),
                .i_base         (base_chain[j]),
                .i_base_col     (col_chain[j]),
                .i_top_m        (m_chain[j]),
                .i_top_i        (i_chain[j]),
                .o_m            (m_chain[j+1]),
                .o_i            (i_chain[j+1]),
                .o_base_valid   (valid_chain[j+1]),
                .o_base         (base_chain[j+1]),
                .o_base_col     (col_chain[j+1]),
                .o_row_best     (o_row_best[j*SCORE_W +: SCORE_W]),
                .o_row_best_col (o_row_best_col[j*COL_W +: COL_W])
            );
        end
    endgenerate

    // the last cell's chain outputs leave the matrix and are not read;
    // row bests of disabled rows stay 0 after the clear and are never scanned

endmodule

// File: verilog/sw_best_select.sv
// scans one row per cycle; result holds until the next start, row bests must be stable meanwhile
`timescale 1ns/10ps

module sw_best_select #(
    parameter  int REF_LEN  = 16,
    parameter  int READ_LEN = 8,
    parameter  int SCORE_W  = 10,
    localparam int COL_W    = (REF_LEN > 1) ? $clog2(REF_LEN) : 1,
    localparam int ROW_W    = (READ_LEN > 1) ? $clog2(READ_LEN) : 1,
    localparam int QLEN_W   = $clog2(READ_LEN) + 1
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        i_start,
    input  logic [QLEN_W-1:0]           i_read_len,
    input  logic [READ_LEN*SCORE_W-1:0] i_row_best,
    input  logic [READ_LEN*COL_W-1:0]   i_row_best_col,
    output logic                        o_done,
    output logic signed [SCORE_W-1:0]   o_score,
    output logic [ROW_W-1:0]            o_row,
    output logic [COL_W-1:0]            o_col
);

    logic                      busy;
    logic [ROW_W-1:0]          row_cnt;
    logic signed [SCORE_W-1:0] cur_score;
    logic [COL_W-1:0]          cur_col;
    logic                      last_row;

    assign cur_score = i_row_best[row_cnt*SCORE_W +: SCORE_W];
    assign cur_col   = i_row_best_col[row_cnt*COL_W +: COL_W];
    assign last_row  = (QLEN_W'(row_cnt) == i_read_len - QLEN_W'(1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy    <= 1'b0;
            row_cnt <= '0;
            o_done  <= 1'b0;
            o_score <= '0;
            o_row   <= '0;
            o_col   <= '0;
        end else begin
            o_done <= 1'b0;
            if (i_start) begin
                busy    <= 1'b1;
                row_cnt <= '0;
                o_score <= '0;
                o_row   <= '0;
                o_col   <= '0;
            end else if (busy) begin
                // strictly greater, so ties keep the lowest row
                if (cur_score > o_score) begin
                    o_score <= cur_score;
                    o_row   <= row_cnt;
                    o_col   <= cur_col;
                end
                if (last_row) begin
                    busy   <= 1'b0;
                    o_done <= 1'b1;
                end else begin
                    row_cnt <= row_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// File: verilog/sw_cell.sv
// one row of the score matrix; expects a gap-free run of valid bases after each clear
`timescale 1ns/10ps

module sw_cell import sw_pkg::*; #(
    parameter  int REF_LEN = 16,
    parameter  int SCORE_W = 10,
    localparam int COL_W   = (REF_LEN > 1) ? $clog2(REF_LEN) : 1
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      i_clear,
    input  logic                      i_row_en,
    input  base_t                     i_read_base,
    input  logic                      i_base_valid,
    input  base_t                     i_base,
    input  logic [COL_W-1:0]          i_base_col,
    input  logic signed [SCORE_W-1:0] i_top_m,
    input  logic signed [SCORE_W-1:0] i_top_i,
    output logic signed [SCORE_W-1:0] o_m,
    output logic signed [SCORE_W-1:0] o_i,
    output logic                      o_base_valid,
    output base_t                     o_base,
    output logic [COL_W-1:0]          o_base_col,
    output logic signed [SCORE_W-1:0] o_row_best,
    output logic [COL_W-1:0]          o_row_best_col
);

    localparam logic signed [SCORE_W-1:0] ZERO     = '0;
    localparam logic signed [SCORE_W-1:0] SC_MATCH = SCORE_W'(MATCH_SCORE);
    localparam logic signed [SCORE_W-1:0] SC_MISS  = SCORE_W'(MISMATCH_SCORE);
    localparam logic signed [SCORE_W-1:0] SC_OPEN  = SCORE_W'(GAP_OPEN);
    localparam logic signed [SCORE_W-1:0] SC_EXT   = SCORE_W'(GAP_EXTEND);

    function automatic logic signed [SCORE_W-1:0] max3(
        input logic signed [SCORE_W-1:0] a,
        input logic signed [SCORE_W-1:0] b,
        input logic signed [SCORE_W-1:0] c
    );
        logic signed [SCORE_W-1:0] ab;
        ab = (a > b) ? a : b;
        return (ab > c) ? ab : c;
    endfunction

    // own D of the previous column, o_m doubles as the left M
    logic signed [SCORE_W-1:0] d_q;
    // upstream row values one column back
    logic signed [SCORE_W-1:0] diag_m;
    logic signed [SCORE_W-1:0] diag_i;
    // upstream D is rebuilt here from the upstream M stream
    logic signed [SCORE_W-1:0] diag_d;

    logic                      step;
    logic signed [SCORE_W-1:0] m_cand;
    logic signed [SCORE_W-1:0] m_new;
    logic signed [SCORE_W-1:0] i_new;
    logic signed [SCORE_W-1:0] d_new;
    logic signed [SCORE_W-1:0] up_d_new;

    assign step     = i_base_valid && i_row_en;
    assign m_cand   = max3(diag_m, diag_i, diag_d) + ((i_base == i_read_base) ? SC_MATCH : SC_MISS);
    assign m_new    = (m_cand > ZERO) ? m_cand : ZERO;
    assign i_new    = max3(i_top_m + SC_OPEN, i_top_i + SC_EXT, ZERO);
    assign d_new    = max3(o_m + SC_OPEN, d_q + SC_EXT, ZERO);
    // same recurrence as d_new, one row up
    assign up_d_new = max3(diag_m + SC_OPEN, diag_d + SC_EXT, ZERO);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_base_valid   <= 1'b0;
            o_m            <= ZERO;
            o_i            <= ZERO;
            d_q            <= ZERO;
            diag_m         <= ZERO;
            diag_i         <= ZERO;
            diag_d         <= ZERO;
            o_row_best     <= ZERO;
            o_row_best_col <= '0;
        end else if (i_clear) begin
            o_base_valid   <= 1'b0;
            o_m            <= ZERO;
            o_i            <= ZERO;
            d_q            <= ZERO;
            diag_m         <= ZERO;
            diag_i         <= ZERO;
            diag_d         <= ZERO;
            o_row_best     <= ZERO;
            o_row_best_col <= '0;
        end else begin
            o_base_valid <= i_base_valid;
            if (step) begin
                o_m    <= m_new;
                o_i    <= i_new;
                d_q    <= d_new;
                diag_m <= i_top_m;
                diag_i <= i_top_i;
                diag_d <= up_d_new;
                // strictly greater keeps the earliest column on ties
                if (m_new > o_row_best) begin
                    o_row_best     <= m_new;
                    o_row_best_col <= i_base_col;
                end
            end
        end
    end

    // base stream to the next row, one cycle later
    always_ff @(posedge clk) begin
        o_base     <= i_base;
        o_base_col <= i_base_col;
    end

endmodule

// File: verilog/sw_core.sv
// Smith-Waterman top with affine gaps; lengths are 1-based, first base in the top pair, no traceback
`timescale 1ns/10ps

module sw_core import sw_pkg::*; #(
    parameter  int REF_LEN  = 16,
    parameter  int READ_LEN = 8,
    parameter  int SCORE_W  = 10,
    localparam int COL_W    = (REF_LEN > 1) ? $clog2(REF_LEN) : 1,
    localparam int ROW_W    = (READ_LEN > 1) ? $clog2(READ_LEN) : 1,
    localparam int RLEN_W   = $clog2(REF_LEN) + 1,
    localparam int QLEN_W   = $clog2(READ_LEN) + 1
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      i_valid,
    input  logic [2*REF_LEN-1:0]      i_seq_ref,
    input  logic [2*READ_LEN-1:0]     i_seq_read,
    input  logic [RLEN_W-1:0]         i_ref_len,
    input  logic [QLEN_W-1:0]         i_read_len,
    output logic                      o_ready,
    input  logic                      i_ready,
    output logic                      o_valid,
    output logic signed [SCORE_W-1:0] o_score,
    output logic [ROW_W-1:0]          o_row,
    output logic [COL_W-1:0]          o_col
);

    logic                        clear;
    logic                        base_valid;
    base_t                       base;
    logic [COL_W-1:0]            base_col;
    logic [2*READ_LEN-1:0]       read_bases;
    logic [QLEN_W-1:0]           read_len;
    logic                        sel_start;
    logic                        sel_done;
    logic [READ_LEN*SCORE_W-1:0] row_best;
    logic [READ_LEN*COL_W-1:0]   row_best_col;

    sw_ctrl #(.REF_LEN(REF_LEN), .READ_LEN(READ_LEN)) ctrl_i (
        .clk(clk), .rst(rst), .i_valid(i_valid), .i_seq_ref(i_seq_ref),
        .i_seq_read(i_seq_read), .i_ref_len(i_ref_len), .i_read_len(i_read_len),
        .i_ready(i_ready), .i_sel_done(sel_done), .o_ready(o_ready), .o_valid(o_valid),
        .o_clear(clear), .o_base_valid(base_valid), .o_base(base), .o_base_col(base_col),
        .o_read_bases(read_bases), .o_read_len(read_len), .o_sel_start(sel_start)
    );

    sw_array #(.REF_LEN(REF_LEN), .READ_LEN(READ_LEN), .SCORE_W(SCORE_W)) array_i (
        .clk(clk), .rst(rst), .i_clear(clear), .i_base_valid(base_valid), .i_base(base),
        .i_base_col(base_col), .i_read_bases(read_bases), .i_read_len(read_len),
        .o_row_best(row_best), .o_row_best_col(row_best_col)
    );

    sw_best_select #(.REF_LEN(REF_LEN), .READ_LEN(READ_LEN), .SCORE_W(SCORE_W)) select_i (
        .clk(clk), .rst(rst), .i_start(sel_start), .i_read_len(read_len),
        .i_row_best(row_best), .i_row_best_col(row_best_col), .o_done(sel_done),
        .o_score(o_score), .o_row(o_row), .o_col(o_col)
    );

endmodule

// File: verilog/sw_ctrl.sv
// job FSM; one job at a time, a new job waits until the result has been taken
`timescale 1ns/10ps

module sw_ctrl import sw_pkg::*; #(
    parameter  int REF_LEN  = 16,
    parameter  int READ_LEN = 8,
    localparam int COL_W    = (REF_LEN > 1) ? $clog2(REF_LEN) : 1,
    localparam int RLEN_W   = $clog2(REF_LEN) + 1,
    localparam int QLEN_W   = $clog2(READ_LEN) + 1,
    localparam int CNT_W    = $clog2(REF_LEN + READ_LEN) + 1
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_valid,
    input  logic [2*REF_LEN-1:0]  i_seq_ref,
    input  logic [2*READ_LEN-1:0] i_seq_read,
    input  logic [RLEN_W-1:0]     i_ref_len,
    input  logic [QLEN_W-1:0]     i_read_len,
    input  logic                  i_ready,
    input  logic                  i_sel_done,
    output logic                  o_ready,
    output logic                  o_valid,
    output logic                  o_clear,
    output logic                  o_base_valid,
    output base_t                 o_base,
    output logic [COL_W-1:0]      o_base_col,
    output logic [2*READ_LEN-1:0] o_read_bases,
    output logic [QLEN_W-1:0]     o_read_len,
    output logic                  o_sel_start
);

    ctrl_state_t          state;
    ctrl_state_t          state_n;
    logic [CNT_W-1:0]     cnt;
    logic [CNT_W-1:0]     last_cnt;
    logic [RLEN_W-1:0]    ref_len;
    logic [2*REF_LEN-1:0] ref_shift;
    logic                 accept;
    logic                 calc_last;

    assign accept    = (state == S_IDLE) && i_valid;
    // wavefront spans ref_len + read_len - 1 cycles
    assign last_cnt  = CNT_W'(ref_len) + CNT_W'(o_read_len) - CNT_W'(2);
    assign calc_last = (state == S_CALC) && (cnt == last_cnt);

    assign o_ready      = (state == S_IDLE);
    assign o_valid      = (state == S_DONE);
    assign o_clear      = accept;
    assign o_sel_start  = calc_last;
    // tail cycles keep the counter running with no new base
    assign o_base_valid = (state == S_CALC) && (cnt < CNT_W'(ref_len));
    assign o_base       = base_t'(ref_shift[2*REF_LEN-1 -: 2]);
    assign o_base_col   = cnt[COL_W-1:0];

    always_comb begin
        state_n = state;
        unique case (state)
            S_IDLE:   if (accept)     state_n = S_CALC;
            S_CALC:   if (calc_last)  state_n = S_SELECT;
            S_SELECT: if (i_sel_done) state_n = S_DONE;
            S_DONE:   if (i_ready)    state_n = S_IDLE;
            default:  state_n = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= S_IDLE;
            cnt   <= '0;
        end else begin
            state <= state_n;
            if (accept) begin
                cnt <= '0;
            end else if (state == S_CALC) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // job payload, captured on accept
    always_ff @(posedge clk) begin
        if (accept) begin
            ref_shift    <= i_seq_ref;
            o_read_bases <= i_seq_read;
            ref_len      <= i_ref_len;
            o_read_len   <= i_read_len;
        end else if (state == S_CALC) begin
            // next reference base moves into the top pair
            ref_shift <= ref_shift << 2;
        end
    end

endmodule

// File: verilog/sw_pkg.sv
// fixed scoring constants for the alignment engine, no run-time configuration; edit here to retune
package sw_pkg;

    // 2-bit nucleotide code as carried on the sequence buses
    typedef enum logic [1:0] {
        BASE_A = 2'd0,
        BASE_C = 2'd1,
        BASE_G = 2'd2,
        BASE_T = 2'd3
    } base_t;

    // job controller states
    typedef enum logic [1:0] {
        S_IDLE   = 2'd0,
        S_CALC   = 2'd1,
        S_SELECT = 2'd2,
        S_DONE   = 2'd3
    } ctrl_state_t;

    // substitution scores
    localparam int MATCH_SCORE    = 2;
    localparam int MISMATCH_SCORE = -1;

    // affine gap penalties, the open cost covers the first gap position
    localparam int GAP_OPEN       = -2;
    localparam int GAP_EXTEND     = -1;

    // scores are floored at 0 inside the cells, so the signed width only
    // needs room for MATCH_SCORE times the longest read plus one sign bit

endpackage
